// File: Makefile
all: run

compile:
	verilator --binary --timing --top-module tbRv32 -f build.f -Mdir obj_dir -o simv

run: compile
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// File: build.f
+incdir+test
design/rvPkg.sv
design/ctrlIf.sv
design/controlFsm.sv
design/progCounter.sv
design/regFile.sv
design/alu.sv
design/unifiedMem.sv
design/datapath.sv
design/rv32Multicycle.sv
test/tbRv32.sv

// File: design/alu.sv
/* ALU with operation decode */

`timescale 1ns/1ps

module alu (
	input rvPkg::aluOp_t aluOp,
	input logic [2:0] funct3,
	input logic funct7b5,
	input logic [rvPkg::XLEN-1:0] a,
	input logic [rvPkg::XLEN-1:0] b,
	output logic [rvPkg::XLEN-1:0] y,
	output logic zero
);

	rvPkg::aluCtrl_t aluCtrl;

	always_comb begin
		case (aluOp)
			rvPkg::OP_ADD: aluCtrl = rvPkg::ALU_ADD;
			rvPkg::OP_SUB: aluCtrl = rvPkg::ALU_SUB;
			default: begin
				// R and I classes share funct3
				case (funct3)
					3'b000: begin
						if (aluOp == rvPkg::OP_RFUNC && funct7b5)
							aluCtrl = rvPkg::ALU_SUB;
						else
							aluCtrl = rvPkg::ALU_ADD;
					end
					3'b010: aluCtrl = rvPkg::ALU_SLT;
					3'b110: aluCtrl = rvPkg::ALU_OR;
					3'b111: aluCtrl = rvPkg::ALU_AND;
					default: aluCtrl = rvPkg::ALU_ADD;
				endcase
			end
		endcase
	end

	always_comb begin
		case (aluCtrl)
			rvPkg::ALU_SUB: y = a - b;
			rvPkg::ALU_AND: y = a & b;
			rvPkg::ALU_OR: y = a | b;
			rvPkg::ALU_SLT: y = {{(rvPkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			default: y = a + b;
		endcase
	end

	assign zero = (y == '0);

endmodule

// File: design/controlFsm.sv
/* Moore control FSM */

`timescale 1ns/1ps

module controlFsm (
	input logic clk,
	input logic reset,
	input rvPkg::opcode_t opcode,
	input logic zero,
	ctrlIf.fsm ctrl,
	output rvPkg::fsmState_t state
);

	rvPkg::fsmState_t nextState;

	always_ff @(posedge clk) begin
		if (reset)
			state <= rvPkg::FETCH;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = rvPkg::FETCH;
		case (state)
			rvPkg::FETCH: nextState = rvPkg::DECODE;
			rvPkg::DECODE: begin
				case (opcode)
					rvPkg::RType: nextState = rvPkg::EXECUTER;
					rvPkg::ITypeLogic: nextState = rvPkg::EXECUTEI;
					rvPkg::ITypeLoad: nextState = rvPkg::MEMADR;
					rvPkg::SType: nextState = rvPkg::MEMADR;
					rvPkg::BType: nextState = rvPkg::BRANCHIFEQ;
					rvPkg::JType: nextState = rvPkg::UNCONDJUMP;
					// unknown word, skip it
					default: nextState = rvPkg::FETCH;
				endcase
			end
			rvPkg::EXECUTER: nextState = rvPkg::ALUWB;
			rvPkg::EXECUTEI: nextState = rvPkg::ALUWB;
			rvPkg::UNCONDJUMP: nextState = rvPkg::ALUWB;
			rvPkg::MEMADR: begin
				if (opcode == rvPkg::ITypeLoad)
					nextState = rvPkg::MEMREAD;
				else
					nextState = rvPkg::MEMWRITE;
			end
			rvPkg::MEMREAD: nextState = rvPkg::MEMWB;
			default: nextState = rvPkg::FETCH;
		endcase
	end

	always_comb begin
		ctrl.adrSrc = rvPkg::ADR_PC;
		ctrl.irWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.pcUpdate = 1'b0;
		ctrl.aluSrcA = rvPkg::SRCA_RD1;
		ctrl.aluSrcB = rvPkg::SRCB_RD2;
		ctrl.aluOp = rvPkg::OP_ADD;
		ctrl.resultSrc = rvPkg::RES_ALU_OUT;
		case (state)
			rvPkg::FETCH: begin
				// read instruction, pc <= pc + 4
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcA = rvPkg::SRCA_PC;
				ctrl.aluSrcB = rvPkg::SRCB_FOUR;
				ctrl.resultSrc = rvPkg::RES_ALU_RESULT;
			end
			rvPkg::DECODE: begin
				// branch or jump target into aluOut
				ctrl.aluSrcA = rvPkg::SRCA_OLD_PC;
				ctrl.aluSrcB = rvPkg::SRCB_IMM_EXT;
			end
			rvPkg::EXECUTER: begin
				ctrl.aluOp = rvPkg::OP_RFUNC;
			end
			rvPkg::EXECUTEI: begin
				ctrl.aluSrcB = rvPkg::SRCB_IMM_EXT;
				ctrl.aluOp = rvPkg::OP_IFUNC;
			end
			rvPkg::UNCONDJUMP: begin
				// take target, compute link value
				ctrl.pcUpdate = 1'b1;
				ctrl.aluSrcA = rvPkg::SRCA_OLD_PC;
				ctrl.aluSrcB = rvPkg::SRCB_FOUR;
			end
			rvPkg::MEMADR: begin
				ctrl.aluSrcB = rvPkg::SRCB_IMM_EXT;
			end
			rvPkg::MEMREAD: begin
				ctrl.adrSrc = rvPkg::ADR_RESULT;
			end
			rvPkg::MEMWRITE: begin
				ctrl.adrSrc = rvPkg::ADR_RESULT;
				ctrl.memWrite = 1'b1;
			end
			rvPkg::MEMWB: begin
				ctrl.resultSrc = rvPkg::RES_DATA;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::ALUWB: begin
				ctrl.regWrite = 1'b1;
			end
			rvPkg::BRANCHIFEQ: begin
				ctrl.aluOp = rvPkg::OP_SUB;
				ctrl.pcUpdate = zero;
			end
			default: ;
		endcase
	end

endmodule

// File: design/ctrlIf.sv
/* Control bus, FSM to datapath */

`timescale 1ns/1ps

interface ctrlIf;

	rvPkg::adrSrc_t adrSrc;
	logic irWrite;
	logic regWrite;
	logic memWrite;
	logic pcWrite;
	logic pcUpdate;
	rvPkg::aluSrcA_t aluSrcA;
	rvPkg::aluSrcB_t aluSrcB;
	rvPkg::aluOp_t aluOp;
	rvPkg::resultSrc_t resultSrc;

	modport fsm (
		output adrSrc, irWrite, regWrite, memWrite, pcWrite, pcUpdate,
		output aluSrcA, aluSrcB, aluOp, resultSrc
	);

	modport dp (
		input adrSrc, irWrite, regWrite, memWrite, pcWrite, pcUpdate,
		input aluSrcA, aluSrcB, aluOp, resultSrc
	);

endinterface

// File: design/datapath.sv
/* Multicycle datapath */

`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic reset,
	ctrlIf.dp ctrl,
	input logic loadEn,
	input logic [rvPkg::MEM_ADDR_BITS-1:0] loadAddr,
	input logic [rvPkg::XLEN-1:0] loadData,
	output rvPkg::opcode_t opcode,
	output logic zero,
	output logic [rvPkg::XLEN-1:0] memAddr,
	output logic [rvPkg::XLEN-1:0] memWdata
);

	logic [rvPkg::XLEN-1:0] pc, oldPc;
	logic [rvPkg::XLEN-1:0] instr, dataReg;
	logic [rvPkg::XLEN-1:0] memRdata;
	logic [rvPkg::XLEN-1:0] rd1, rd2, regA, regB;
	logic [rvPkg::XLEN-1:0] immExt;
	logic [rvPkg::XLEN-1:0] srcA, srcB, aluResult, aluOut;
	logic [rvPkg::XLEN-1:0] result;

	progCounter uPc (
		.clk(clk),
		.reset(reset),
		.pcWrite(ctrl.pcWrite),
		.pcUpdate(ctrl.pcUpdate),
		.nextPc(result),
		.target(aluOut),
		.pc(pc),
		.oldPc(oldPc)
	);

	// loader only acts while the core is held in reset
	unifiedMem uMem (
		.clk(clk),
		.we(ctrl.memWrite),
		.addr(memAddr),
		.wd(regB),
		.rd(memRdata),
		.loadEn(loadEn & reset),
		.loadAddr(loadAddr),
		.loadData(loadData)
	);

	always_ff @(posedge clk) begin
		if (ctrl.irWrite)
			instr <= memRdata;
		dataReg <= memRdata;
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
	end

	assign opcode = rvPkg::opcode_t'(instr[6:0]);

	regFile uRegs (
		.clk(clk),
		.we(ctrl.regWrite),
		.ra1(instr[19:15]),
		.ra2(instr[24:20]),
		.wa(instr[11:7]),
		.wd(result),
		.rd1(rd1),
		.rd2(rd2)
	);

	// immediate format follows the opcode
	always_comb begin
		case (opcode)
			rvPkg::SType: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rvPkg::BType: immExt = {{19{instr[31]}}, instr[31], instr[7],
				instr[30:25], instr[11:8], 1'b0};
			rvPkg::JType: immExt = {{11{instr[31]}}, instr[31], instr[19:12],
				instr[20], instr[30:21], 1'b0};
			default: immExt = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	always_comb begin
		case (ctrl.aluSrcA)
			rvPkg::SRCA_PC: srcA = pc;
			rvPkg::SRCA_OLD_PC: srcA = oldPc;
			default: srcA = regA;
		endcase
		case (ctrl.aluSrcB)
			rvPkg::SRCB_IMM_EXT: srcB = immExt;
			rvPkg::SRCB_FOUR: srcB = 32'd4;
			default: srcB = regB;
		endcase
		case (ctrl.resultSrc)
			rvPkg::RES_DATA: result = dataReg;
			rvPkg::RES_ALU_RESULT: result = aluResult;
			default: result = aluOut;
		endcase
	end

	alu uAlu (
		.aluOp(ctrl.aluOp),
		.funct3(instr[14:12]),
		.funct7b5(instr[30]),
		.a(srcA),
		.b(srcB),
		.y(aluResult),
		.zero(zero)
	);

	assign memAddr = (ctrl.adrSrc == rvPkg::ADR_RESULT) ? result : pc;
	assign memWdata = regB;

endmodule

// File: design/progCounter.sv
/* Program counter unit */

`timescale 1ns/1ps

module progCounter (
	input logic clk,
	input logic reset,
	input logic pcWrite,
	input logic pcUpdate,
	input logic [rvPkg::XLEN-1:0] nextPc,
	input logic [rvPkg::XLEN-1:0] target,
	output logic [rvPkg::XLEN-1:0] pc,
	output logic [rvPkg::XLEN-1:0] oldPc
);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			oldPc <= '0;
		end else if (pcWrite) begin
			// keep address of the instruction being fetched
			oldPc <= pc;
			pc <= nextPc;
		end else if (pcUpdate) begin
			pc <= target;
		end
	end

endmodule

// File: design/regFile.sv
/* Integer register file */

`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic we,
	input logic [rvPkg::REG_ADDR_BITS-1:0] ra1,
	input logic [rvPkg::REG_ADDR_BITS-1:0] ra2,
	input logic [rvPkg::REG_ADDR_BITS-1:0] wa,
	input logic [rvPkg::XLEN-1:0] wd,
	output logic [rvPkg::XLEN-1:0] rd1,
	output logic [rvPkg::XLEN-1:0] rd2
);

	logic [rvPkg::XLEN-1:0] regs [2**rvPkg::REG_ADDR_BITS];

	always_ff @(posedge clk) begin
		if (we && (wa != '0))
			regs[wa] <= wd;
	end

	// x0 is hardwired to zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: design/rv32Multicycle.sv
/* RV32I multicycle core top */

`timescale 1ns/1ps

module rv32Multicycle (
	input logic clk,
	input logic reset,
	input logic loadEn,
	input logic [rvPkg::MEM_ADDR_BITS-1:0] loadAddr,
	input logic [rvPkg::XLEN-1:0] loadData,
	output logic storeValid,
	output logic [rvPkg::XLEN-1:0] storeAddr,
	output logic [rvPkg::XLEN-1:0] storeData
);

	rvPkg::opcode_t opcode;
	logic zero;

	ctrlIf ctrlBus ();

	controlFsm uFsm (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.zero(zero),
		.ctrl(ctrlBus.fsm),
		.state()
	);

	datapath uDatapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.dp),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.opcode(opcode),
		.zero(zero),
		.memAddr(storeAddr),
		.memWdata(storeData)
	);

	// high only in MEMWRITE
	assign storeValid = ctrlBus.memWrite;

endmodule

// File: design/rvPkg.sv
/* RV32I multicycle core definitions */

package rvPkg;

	localparam int XLEN = 32;
	localparam int MEM_WORDS = 256;
	localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
	localparam int REG_ADDR_BITS = 5;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		RType      = 7'b0110011,
		ITypeLogic = 7'b0010011,
		ITypeLoad  = 7'b0000011,
		SType      = 7'b0100011,
		BType      = 7'b1100011,
		JType      = 7'b1101111
	} opcode_t;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		EXECUTER,
		EXECUTEI,
		UNCONDJUMP,
		MEMADR,
		MEMREAD,
		MEMWRITE,
		MEMWB,
		ALUWB,
		BRANCHIFEQ
	} fsmState_t;

	typedef enum logic {ADR_PC, ADR_RESULT} adrSrc_t;

	typedef enum logic [1:0] {SRCA_PC, SRCA_OLD_PC, SRCA_RD1} aluSrcA_t;

	typedef enum logic [1:0] {SRCB_RD2, SRCB_IMM_EXT, SRCB_FOUR} aluSrcB_t;

	typedef enum logic [1:0] {RES_ALU_OUT, RES_DATA, RES_ALU_RESULT} resultSrc_t;

	// operation class from the FSM
	typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_RFUNC, OP_IFUNC} aluOp_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluCtrl_t;

endpackage

// File: design/unifiedMem.sv
/* Shared instruction and data memory */

`timescale 1ns/1ps

module unifiedMem (
	input logic clk,
	input logic we,
	input logic [rvPkg::XLEN-1:0] addr,
	input logic [rvPkg::XLEN-1:0] wd,
	output logic [rvPkg::XLEN-1:0] rd,
	input logic loadEn,
	input logic [rvPkg::MEM_ADDR_BITS-1:0] loadAddr,
	input logic [rvPkg::XLEN-1:0] loadData
);

	logic [rvPkg::XLEN-1:0] mem [rvPkg::MEM_WORDS];
	logic [rvPkg::MEM_ADDR_BITS-1:0] wordIdx;

	// word address, byte offset dropped
	assign wordIdx = addr[rvPkg::MEM_ADDR_BITS+1:2];

	always_ff @(posedge clk) begin
		// loader has priority over the core
		if (loadEn)
			mem[loadAddr] <= loadData;
		else if (we)
			mem[wordIdx] <= wd;
	end

	assign rd = mem[wordIdx];

endmodule

// File: test/tbProgram.svh
/* Test programs and expected stores */

localparam int NUM_TESTS = 6;
localparam int MAX_WORDS = 32;
localparam int MAX_STORES = 12;
localparam logic [6:0] OP_IMM = 7'b0010011;
localparam logic [6:0] OP_LOAD = 7'b0000011;
// a store to this address ends each program
localparam logic [rvPkg::XLEN-1:0] DONE_ADDR = 32'h0000_03FC;

string testName [NUM_TESTS];
logic [rvPkg::XLEN-1:0] prog [NUM_TESTS][MAX_WORDS];
int progLen [NUM_TESTS];
logic [rvPkg::XLEN-1:0] expAddr [NUM_TESTS][MAX_STORES];
logic [rvPkg::XLEN-1:0] expData [NUM_TESTS][MAX_STORES];
int expCount [NUM_TESTS];
int unsigned lcgState;

function automatic int nextRandom();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return int'(lcgState[27:16]);
endfunction

// RV32I instruction formats
function automatic logic [31:0] rFormat(input int f7, input int rs2, input int rs1,
	input int f3, input int rd);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] iFormat(input logic [6:0] opc, input int f3, input int rd,
	input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] sFormat(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] bFormat(input int rs2, input int rs1, input int imm);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jFormat(input int rd, input int imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic addWord(input int t, input logic [rvPkg::XLEN-1:0] w);
	prog[t][progLen[t]] = w;
	progLen[t]++;
endtask

task automatic expectStore(input int t, input logic [rvPkg::XLEN-1:0] addr,
	input logic [rvPkg::XLEN-1:0] data);
	expAddr[t][expCount[t]] = addr;
	expData[t][expCount[t]] = data;
	expCount[t]++;
endtask

// one operation, then sw of its rd with base x0
task automatic opStore(input int t, input logic [rvPkg::XLEN-1:0] w, input int rd,
	input int addr, input logic [rvPkg::XLEN-1:0] data);
	addWord(t, w);
	addWord(t, sFormat(rd, 0, addr));
	expectStore(t, addr, data);
endtask

// done store, then jal x0 to itself
task automatic endProgram(input int t);
	addWord(t, sFormat(0, 0, DONE_ADDR));
	addWord(t, jFormat(0, 0));
endtask

task automatic buildTables();
	int a;
	int b;
	int imm;
	int sum;
	int link;
	int t;
	int k;
	a = 90;
	b = -7;
	sum = 0;
	lcgState = 5;
	for (t = 0; t < NUM_TESTS; t++) begin
		progLen[t] = 0;
		expCount[t] = 0;
	end

	testName[0] = "arithmetic";
	addWord(0, iFormat(OP_IMM, 0, 1, 0, a));
	addWord(0, iFormat(OP_IMM, 0, 2, 0, b));
	opStore(0, rFormat(0, 2, 1, 0, 3), 3, 'h100, a + b);
	opStore(0, rFormat(32, 2, 1, 0, 4), 4, 'h104, a - b);
	opStore(0, rFormat(0, 2, 1, 7, 5), 5, 'h108, a & b);
	opStore(0, rFormat(0, 2, 1, 6, 6), 6, 'h10C, a | b);
	opStore(0, rFormat(0, 1, 2, 2, 7), 7, 'h110, (b < a) ? 1 : 0);
	opStore(0, rFormat(0, 2, 1, 2, 8), 8, 'h114, (a < b) ? 1 : 0);
	opStore(0, iFormat(OP_IMM, 7, 9, 1, 15), 9, 'h118, a & 15);
	opStore(0, iFormat(OP_IMM, 6, 10, 2, 'h106), 10, 'h11C, b | 'h106);
	opStore(0, iFormat(OP_IMM, 2, 11, 2, -3), 11, 'h120, (b < -3) ? 1 : 0);
	endProgram(0);

	testName[1] = "random addi";
	for (k = 0; k < 8; k++) begin
		imm = nextRandom();
		addWord(1, iFormat(OP_IMM, 0, 1, (k == 0) ? 0 : 1, imm));
		// 12-bit field taken as signed
		sum += (imm >= 2048) ? imm - 4096 : imm;
	end
	addWord(1, sFormat(1, 0, 'h200));
	expectStore(1, 'h200, sum);
	endProgram(1);

	testName[2] = "memory";
	addWord(2, iFormat(OP_IMM, 0, 4, 0, 'h140));
	addWord(2, iFormat(OP_IMM, 0, 1, 0, 1234));
	addWord(2, sFormat(1, 4, 0));
	expectStore(2, 'h140, 1234);
	addWord(2, iFormat(OP_LOAD, 2, 2, 4, 0));
	addWord(2, iFormat(OP_IMM, 0, 3, 2, 1));
	addWord(2, sFormat(3, 4, 4));
	expectStore(2, 'h144, 1234 + 1);
	endProgram(2);

	testName[3] = "beq";
	addWord(3, iFormat(OP_IMM, 0, 1, 0, 5));
	addWord(3, iFormat(OP_IMM, 0, 2, 0, 5));
	addWord(3, iFormat(OP_IMM, 0, 3, 0, 9));
	// x1 != x3, falls through to the store
	addWord(3, bFormat(3, 1, 8));
	addWord(3, sFormat(1, 0, 'h180));
	expectStore(3, 'h180, 5);
	// x1 == x2, marker store is skipped
	addWord(3, bFormat(2, 1, 8));
	addWord(3, sFormat(3, 0, 'h184));
	addWord(3, iFormat(OP_IMM, 0, 4, 0, 77));
	addWord(3, sFormat(4, 0, 'h188));
	expectStore(3, 'h188, 77);
	endProgram(3);

	testName[4] = "jal";
	addWord(4, iFormat(OP_IMM, 0, 5, 0, 3));
	link = progLen[4] * 4 + 4;
	addWord(4, jFormat(1, 8));
	addWord(4, sFormat(5, 0, 'h1C0));
	addWord(4, sFormat(1, 0, 'h1C4));
	expectStore(4, 'h1C4, link);
	endProgram(4);

	testName[5] = "unknown opcode";
	addWord(5, iFormat(OP_IMM, 0, 1, 0, 42));
	addWord(5, 32'h0000_0000);
	addWord(5, sFormat(1, 0, 'h1E0));
	expectStore(5, 'h1E0, 42);
	endProgram(5);
endtask

// File: test/tbRv32.sv
/* Multicycle core testbench */

`timescale 1ns/1ps

module tbRv32;

	localparam int RESET_CYCLES = 10;

	logic clk;
	logic reset;
	logic loadEn;
	logic [rvPkg::MEM_ADDR_BITS-1:0] loadAddr;
	logic [rvPkg::XLEN-1:0] loadData;
	logic storeValid;
	logic [rvPkg::XLEN-1:0] storeAddr;
	logic [rvPkg::XLEN-1:0] storeData;

	int errCount;
	int passCount;
	int failCount;
	int cycleCount;
	int cycleLimit;

	`include "tbProgram.svh"

	rv32Multicycle uut (
		.clk(clk),
		.reset(reset),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, a program never reached its done store",
				cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	task automatic checkWord(input string what, input logic [rvPkg::XLEN-1:0] got,
		input logic [rvPkg::XLEN-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic checkCount(input int got, input int exp);
		if (got != exp) begin
			$display("** Error at %0t: store count is %0d, expected %0d", $time, got, exp);
			errCount++;
		end
	endtask

	// reset and load, then collect stores until the done store
	task runTest(input int t);
		int i;
		int n;
		int loadCycles;
		int errBefore;
		bit done;
		errBefore = errCount;
		n = 0;
		done = 0;
		loadCycles = (progLen[t] > RESET_CYCLES) ? progLen[t] : RESET_CYCLES;
		@(negedge clk);
		reset = 1'b1;
		for (i = 0; i < loadCycles; i++) begin
			loadEn = (i < progLen[t]);
			loadAddr = i[rvPkg::MEM_ADDR_BITS-1:0];
			if (i < progLen[t])
				loadData = prog[t][i];
			@(negedge clk);
		end
		loadEn = 1'b0;
		reset = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (storeValid) begin
				if (storeAddr == DONE_ADDR) begin
					done = 1;
				end else begin
					if (n < expCount[t]) begin
						checkWord("store address", storeAddr, expAddr[t][n]);
						checkWord("store data", storeData, expData[t][n]);
					end else begin
						$display("extra store to address %h in test %0d", storeAddr, t);
					end
					n++;
				end
			end
		end
		checkCount(n, expCount[t]);
		if (errCount == errBefore) begin
			passCount++;
			$display("test %0d %s: %0d stores, passed", t, testName[t], n);
		end else begin
			failCount++;
			$display("test %0d %s: %0d stores, FAILED", t, testName[t], n);
		end
	endtask

	initial begin
		int t;
		clk = 1'b0;
		reset = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		errCount = 0;
		passCount = 0;
		failCount = 0;
		cycleCount = 0;
		buildTables();
		// five cycles per word at most, plus slack for loading
		cycleLimit = 0;
		for (t = 0; t < NUM_TESTS; t++)
			cycleLimit += progLen[t] * 5 + 50;
		for (t = 0; t < NUM_TESTS; t++)
			runTest(t);
		$display("%0d tests: %0d passed, %0d failed, %0d errors",
			NUM_TESTS, passCount, failCount, errCount);
		if (errCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
